//--- rv_mem_pkg.sv
// ------------------------------
// rv mem package
// memory op encoding, word and lane widths, op decode helpers
// ------------------------------
`default_nettype none

package rv_mem_pkg;

    localparam int xlen     = 32;           // data word width
    localparam int byte_cnt = xlen / 8;     // byte lanes per word
    localparam int baddr_w  = 2;            // lane select bits in a byte address

    // load/store operations issued by execute
    typedef enum logic [2:0] {
        op_lb  = 3'd0,
        op_lh  = 3'd1,
        op_lw  = 3'd2,
        op_lbu = 3'd3,
        op_lhu = 3'd4,
        op_sb  = 3'd5,
        op_sh  = 3'd6,
        op_sw  = 3'd7
    } mem_op_e;

    function automatic logic is_store(mem_op_e op);
        return op inside {op_sb, op_sh, op_sw};
    endfunction

    function automatic logic is_load(mem_op_e op);
        return op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
    endfunction

    // access width in bytes, 1 / 2 / 4
    function automatic logic [2:0] access_size(mem_op_e op);
        case (op)
            op_lb, op_lbu, op_sb: return 3'd1;
            op_lh, op_lhu, op_sh: return 3'd2;
            default:              return 3'd4;   // lw, sw
        endcase
    endfunction

endpackage

`default_nettype wire

//--- store_align.sv
// ------------------------------
// store aligner
// turns store op and lane offset into byte enables
// and lane-placed write data, flags misaligned accesses
// ------------------------------
`default_nettype none

module store_align (
    input  logic                          req,
    input  rv_mem_pkg::mem_op_e           op,
    input  logic [rv_mem_pkg::baddr_w-1:0] addr_lo,
    input  logic [rv_mem_pkg::xlen-1:0]    wdata,
    output logic [rv_mem_pkg::byte_cnt-1:0] byte_en,
    output logic [rv_mem_pkg::xlen-1:0]    lane_data,
    output logic                          misaligned
);

    logic [2:0]                        size;        // bytes per access
    logic [rv_mem_pkg::baddr_w-1:0]    align_mask;  // low bits that must be clear
    logic [rv_mem_pkg::byte_cnt-1:0]   base_en;     // enables before lane shift
    logic                              wr_ok;

    assign size = rv_mem_pkg::access_size(op);

    // 1 -> 00, 2 -> 01, 4 -> 11
    assign align_mask = size[rv_mem_pkg::baddr_w-1:0] - 1'b1;

    // applies to loads and stores alike, top level uses it for the read strobe
    assign misaligned = req && ((addr_lo & align_mask) != '0);

    assign wr_ok = req && rv_mem_pkg::is_store(op) && !misaligned;

    // lanes covered by the access, anchored at lane 0
    always_comb begin
        case (size)
            3'd1:    base_en = 4'b0001;
            3'd2:    base_en = 4'b0011;
            default: base_en = 4'b1111;
        endcase
    end

    // shift to the addressed lane, kill everything on a non-store
    assign byte_en = wr_ok ? (base_en << addr_lo) : '0;

    // replicate the payload into every lane slot
    // whichever lanes are enabled then pick up the right bits
    always_comb begin
        case (op)
            rv_mem_pkg::op_sb: lane_data = {4{wdata[7:0]}};    // byte in all 4 lanes
            rv_mem_pkg::op_sh: lane_data = {2{wdata[15:0]}};   // half in both halves
            default:           lane_data = wdata;              // sw, loads don't care
        endcase
    end

    // an aligned store keeps every lane it covers inside the word
    // a wrong alignment mask would shift lanes out of the top
    always_comb begin
        assert final (!wr_ok || ($countones(byte_en) == size))
            else $error("store_align: byte_en %b does not cover %0d bytes at lane %0d",
                        byte_en, size, addr_lo);
    end

endmodule

`default_nettype wire

//--- data_mem.sv
// ------------------------------
// data memory
// byte-lane word array, writes and read capture on falling clk
// ------------------------------
`default_nettype none

module data_mem #(
    parameter int mem_words = 1024          // depth in 32-bit words
) (
    input  logic                                         clk,
    input  logic                                         nrst,
    input  logic [rv_mem_pkg::xlen-rv_mem_pkg::baddr_w-1:0] word_addr,
    input  logic [rv_mem_pkg::byte_cnt-1:0]              byte_en,
    input  logic [rv_mem_pkg::xlen-1:0]                  lane_data,
    input  logic                                         mem_rd,
    output logic [rv_mem_pkg::xlen-1:0]                  raw_word
);

    // index width, one bit minimum for a single-word array
    localparam int idx_w = (mem_words > 1) ? $clog2(mem_words) : 1;

    // word array as lanes of bytes
    logic [rv_mem_pkg::byte_cnt-1:0][7:0] mem [mem_words];

    logic [idx_w-1:0] idx;      // word index, wraps at mem_words

    assign idx = word_addr[idx_w-1:0];

    // lane writes on the falling edge
    // request was launched on the previous rising edge, so
    // enables and data have had half a cycle to settle
    always_ff @(negedge clk) begin
        for (int i = 0; i < rv_mem_pkg::byte_cnt; i++) begin
            if (byte_en[i]) begin
                mem[idx][i] <= lane_data[8*i +: 8];
            end
        end
    end

    // registered read, same falling edge
    // nonblocking so a same-edge write would not be seen (read first)
    always_ff @(negedge clk) begin
        if (!nrst) begin
            raw_word <= '0;
        end else if (mem_rd) begin
            raw_word <= mem[idx];               // full word, lane pick happens later
        end
    end

    // read strobe comes from the top level, byte enables from the aligner
    // both derive from one op so they must never overlap
    a_rd_wr_excl : assert property (
        @(negedge clk) disable iff (!nrst)
        !(mem_rd && (|byte_en))
    ) else $error("data_mem: read and write in the same cycle, byte_en=%b", byte_en);

    // no silent wrap of the word index on an active access
    a_addr_range : assert property (
        @(negedge clk) disable iff (!nrst)
        (mem_rd || (|byte_en)) |-> (word_addr < mem_words)
    ) else $error("data_mem: word_addr 0x%0h beyond depth %0d", word_addr, mem_words);

    // written data is seen by the next read of the same word
    a_wr_then_rd : assert property (
        @(negedge clk) disable iff (!nrst)
        (byte_en == 4'b1111) ##1 (mem_rd && (idx == $past(idx)))
        |=> (raw_word == $past(lane_data, 2))
    ) else $error("data_mem: word store not returned by following read");

endmodule

`default_nettype wire

//--- load_extend.sv
// ------------------------------
// load extender
// picks the addressed byte or half from the read word,
// sign/zero extends it, registers rdata and load_valid
// ------------------------------
`default_nettype none

module load_extend (
    input  logic                           clk,
    input  logic                           nrst,
    input  logic                           req,
    input  rv_mem_pkg::mem_op_e            op,
    input  logic [rv_mem_pkg::baddr_w-1:0] addr_lo,
    input  logic                           misaligned,
    input  logic [rv_mem_pkg::xlen-1:0]    raw_word,
    output logic [rv_mem_pkg::xlen-1:0]    rdata,
    output logic                           load_valid
);

    logic                        ld_hit;     // aligned load in this cycle
    logic                        sgn;        // lb/lh sign extend
    logic [2:0]                  size;
    logic [rv_mem_pkg::xlen-1:0] lane_word;  // addressed lane moved to bit 0
    logic [rv_mem_pkg::xlen-1:0] ext_word;

    // misaligned comes from the aligner, no second alignment check here
    assign ld_hit = req && rv_mem_pkg::is_load(op) && !misaligned;

    assign sgn  = (op == rv_mem_pkg::op_lb) || (op == rv_mem_pkg::op_lh);
    assign size = rv_mem_pkg::access_size(op);

    // raw_word was captured on the falling edge of this same cycle
    assign lane_word = raw_word >> {addr_lo, 3'b000};

    always_comb begin
        case (size)
            3'd1: begin
                // byte, top bit 7
                ext_word = {{(rv_mem_pkg::xlen-8){sgn & lane_word[7]}}, lane_word[7:0]};
            end
            3'd2: begin
                // halfword, top bit 15
                ext_word = {{(rv_mem_pkg::xlen-16){sgn & lane_word[15]}}, lane_word[15:0]};
            end
            default: begin
                ext_word = lane_word;           // lw, offset is 0 here
            end
        endcase
    end

    // completion on the rising edge after the request
    always_ff @(posedge clk) begin
        if (!nrst) begin
            load_valid <= 1'b0;
            rdata      <= '0;
        end else begin
            load_valid <= ld_hit;               // one-cycle pulse per load
            if (ld_hit) begin
                rdata <= ext_word;              // holds until the next load
            end
        end
    end

    // two valid cycles in a row need two requests in a row
    a_valid_one_per_req : assert property (
        @(posedge clk) disable iff (!nrst)
        (load_valid && $past(load_valid)) |-> ($past(req) && $past(req, 2))
    ) else $error("load_extend: load_valid held for two cycles after a single request");

endmodule

`default_nettype wire

//--- dmem_subsys.sv
// ------------------------------
// data memory subsystem
// store aligner, byte-lane memory and load extender
// between execute and the data array
// ------------------------------
`default_nettype none

module dmem_subsys #(
    parameter int mem_words = 1024          // passed down to the array
) (
    input  logic                        clk,
    input  logic                        nrst,
    input  logic                        req,        // one access per cycle
    input  rv_mem_pkg::mem_op_e         op,
    input  logic [rv_mem_pkg::xlen-1:0] addr,       // byte address
    input  logic [rv_mem_pkg::xlen-1:0] wdata,
    output logic [rv_mem_pkg::xlen-1:0] rdata,
    output logic                        load_valid,
    output logic                        misaligned
);

    localparam int waddr_w = rv_mem_pkg::xlen - rv_mem_pkg::baddr_w;

    logic [waddr_w-1:0]                 word_addr;
    logic [rv_mem_pkg::baddr_w-1:0]     addr_lo;    // lane offset
    logic [rv_mem_pkg::byte_cnt-1:0]    byte_en;
    logic [rv_mem_pkg::xlen-1:0]        lane_data;
    logic [rv_mem_pkg::xlen-1:0]        raw_word;
    logic                               mem_rd;

    // split byte address into word index and lane bits
    assign word_addr = addr[rv_mem_pkg::xlen-1:rv_mem_pkg::baddr_w];
    assign addr_lo   = addr[rv_mem_pkg::baddr_w-1:0];

    // read only for aligned loads
    assign mem_rd = req && rv_mem_pkg::is_load(op) && !misaligned;

    store_align i_store_align (
        .req        (req),
        .op         (op),
        .addr_lo    (addr_lo),
        .wdata      (wdata),
        .byte_en    (byte_en),
        .lane_data  (lane_data),
        .misaligned (misaligned)
    );

    data_mem #(
        .mem_words (mem_words)
    ) i_data_mem (
        .clk       (clk),
        .nrst      (nrst),
        .word_addr (word_addr),
        .byte_en   (byte_en),
        .lane_data (lane_data),
        .mem_rd    (mem_rd),
        .raw_word  (raw_word)
    );

    // sees the live request, result lands on the next rising edge
    load_extend i_load_extend (
        .clk        (clk),
        .nrst       (nrst),
        .req        (req),
        .op         (op),
        .addr_lo    (addr_lo),
        .misaligned (misaligned),
        .raw_word   (raw_word),
        .rdata      (rdata),
        .load_valid (load_valid)
    );

endmodule

`default_nettype wire

//--- tb_dmem_subsys.sv
// ------------------------------
// dmem subsystem testbench
// lfsr load/store traffic checked against a byte shadow model
// ------------------------------
`default_nettype none

module tb_dmem_subsys;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int tb_words = 64;               // small depth, addresses collide often
    localparam int tb_bytes = tb_words * 4;
    localparam int wait_max = 16;               // cycles before a wait gives up
    localparam int n_random = 400;

    logic                clk;
    logic                nrst;
    logic                req;
    rv_mem_pkg::mem_op_e op;
    logic [31:0]         addr;
    logic [31:0]         wdata;
    logic [31:0]         rdata;
    logic                load_valid;
    logic                misaligned;

    logic [7:0]  shadow [tb_bytes];             // reference byte image
    logic [31:0] lfsr = 32'd36;
    logic        exp_valid = 1'b0;              // model view of the request on the bus
    logic        exp_mis = 1'b0;
    logic [31:0] exp_rdata = '0;
    logic        chk_valid;                     // one cycle later, lines up with load_valid
    logic [31:0] chk_rdata;
    logic        load_seen;                     // first load has completed
    int          n_value_err = 0;
    int          n_proto_err = 0;
    int          n_timeout = 0;

    dmem_subsys #(
        .mem_words (tb_words)
    ) i_dmem_subsys (
        .clk        (clk),
        .nrst       (nrst),
        .req        (req),
        .op         (op),
        .addr       (addr),
        .wdata      (wdata),
        .rdata      (rdata),
        .load_valid (load_valid),
        .misaligned (misaligned)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                 // 40 ns period
    end

    // delay the expectation by one cycle so it meets the registered result
    always @(posedge clk) begin
        if (!nrst) begin
            chk_valid <= 1'b0;
            chk_rdata <= '0;
            load_seen <= 1'b0;
        end else begin
            chk_valid <= exp_valid;
            chk_rdata <= exp_rdata;
            if (chk_valid) begin
                load_seen <= 1'b1;
            end
        end
    end

    // checks run on the falling edge, everything driven at posedge is settled
    a_load_valid : assert property (
        @(negedge clk) disable iff (!nrst)
        load_valid == chk_valid
    ) else begin
        n_proto_err++;
        if (chk_valid) begin
            $display("load_valid missing for an aligned load at %0t", $time);
        end else begin
            $display("unexpected load_valid with no aligned load pending at %0t", $time);
        end
    end

    a_rdata : assert property (
        @(negedge clk) disable iff (!nrst)
        chk_valid |-> (rdata == chk_rdata)
    ) else begin
        n_value_err++;
        $display("CHECK FAILED rdata exp 0x%08h got 0x%08h", chk_rdata, rdata);
    end

    a_misaligned : assert property (
        @(negedge clk) disable iff (!nrst)
        misaligned == exp_mis
    ) else begin
        n_value_err++;
        $display("CHECK FAILED misaligned exp 0x%0h got 0x%0h", exp_mis, misaligned);
    end

    // nothing completed yet, outputs still at reset values
    a_reset_state : assert property (
        @(negedge clk) disable iff (!nrst)
        (!load_seen && !chk_valid) |-> (rdata == '0)
    ) else begin
        n_value_err++;
        $display("CHECK FAILED rdata before first load exp 0x00000000 got 0x%08h", rdata);
    end

    // galois step, right shift, one call per bit
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        logic fb;
        fb = s[0];
        s = s >> 1;
        if (fb) begin
            s = s ^ 32'h8020_0003;
        end
        return s;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // preload value, every address bit matters
    function automatic logic [7:0] fill_byte(int b);
        return 8'(b * 37 + 11);
    endfunction

    function automatic int op_bytes(rv_mem_pkg::mem_op_e o);
        case (o)
            rv_mem_pkg::op_lb, rv_mem_pkg::op_lbu, rv_mem_pkg::op_sb: return 1;
            rv_mem_pkg::op_lh, rv_mem_pkg::op_lhu, rv_mem_pkg::op_sh: return 2;
            default: return 4;
        endcase
    endfunction

    // expected load result from the shadow bytes
    function automatic logic [31:0] model_load(rv_mem_pkg::mem_op_e o, logic [7:0] a);
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = shadow[a];
        b1 = shadow[{a[7:1], 1'b1}];            // upper byte of an aligned half
        case (o)
            rv_mem_pkg::op_lb:  return {{24{b0[7]}}, b0};
            rv_mem_pkg::op_lbu: return {24'h0, b0};
            rv_mem_pkg::op_lh:  return {{16{b1[7]}}, b1, b0};
            rv_mem_pkg::op_lhu: return {16'h0, b1, b0};
            default: return {shadow[{a[7:2], 2'd3}], shadow[{a[7:2], 2'd2}],
                             shadow[{a[7:2], 2'd1}], shadow[{a[7:2], 2'd0}]};
        endcase
    endfunction

    function automatic void model_store(rv_mem_pkg::mem_op_e o, logic [7:0] a,
                                        logic [31:0] d);
        case (o)
            rv_mem_pkg::op_sb: shadow[a] = d[7:0];
            rv_mem_pkg::op_sh: begin
                shadow[{a[7:1], 1'b0}] = d[7:0];
                shadow[{a[7:1], 1'b1}] = d[15:8];
            end
            default: begin
                for (int i = 0; i < 4; i++) begin
                    shadow[{a[7:2], 2'(i)}] = d[8*i +: 8];
                end
            end
        endcase
    endfunction

    // one request on the next rising edge, model updated alongside
    task automatic issue(rv_mem_pkg::mem_op_e o, logic [7:0] a, logic [31:0] d);
        logic mis;
        logic ld;
        @(posedge clk);
        mis = (op_bytes(o) == 2 && a[0]) || (op_bytes(o) == 4 && a[1:0] != 2'b00);
        ld  = o inside {rv_mem_pkg::op_lb, rv_mem_pkg::op_lh, rv_mem_pkg::op_lw,
                        rv_mem_pkg::op_lbu, rv_mem_pkg::op_lhu};
        req       <= 1'b1;
        op        <= o;
        addr      <= {24'h0, a};
        wdata     <= d;
        exp_mis   <= mis;
        exp_valid <= ld && !mis;
        if (ld && !mis) begin
            exp_rdata <= model_load(o, a);
        end
        if (!ld && !mis) begin
            model_store(o, a, d);               // misaligned stores leave memory alone
        end
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            req       <= 1'b0;
            exp_valid <= 1'b0;
            exp_mis   <= 1'b0;
        end
    endtask

    // completion of the last load, called right after idle(1)
    task automatic wait_load();
        int  n;
        logic done;
        n = 0;
        done = 1'b0;
        while (!done && n < wait_max) begin
            @(negedge clk);
            done = load_valid;
            n++;
        end
        if (!done) begin
            n_timeout++;
            $display("timeout: load did not complete within %0d cycles", wait_max);
        end
    endtask

    initial begin
        rv_mem_pkg::mem_op_e r_op;
        logic [7:0]          r_addr;
        nrst  = 1'b0;
        req   = 1'b0;
        op    = rv_mem_pkg::op_lw;
        addr  = '0;
        wdata = '0;
        repeat (4) @(posedge clk);
        nrst <= 1'b1;
        idle(3);                                // reset state checked here

        // fill every word, bytes with top bit set and clear
        for (int w = 0; w < tb_words; w++) begin
            issue(rv_mem_pkg::op_sw, 8'(w * 4), {fill_byte(w*4+3), fill_byte(w*4+2),
                                                 fill_byte(w*4+1), fill_byte(w*4)});
        end

        // word store then word load, back to back
        issue(rv_mem_pkg::op_sw, 8'h40, 32'hdead_beef);
        issue(rv_mem_pkg::op_lw, 8'h40, '0);
        idle(1);
        wait_load();

        // partial stores touch only their lanes
        issue(rv_mem_pkg::op_sb, 8'h45, 32'h1234_56a5);
        issue(rv_mem_pkg::op_sh, 8'h4a, 32'hcafe_8001);
        issue(rv_mem_pkg::op_sb, 8'h53, 32'h0000_0077);
        issue(rv_mem_pkg::op_lw, 8'h44, '0);
        issue(rv_mem_pkg::op_lw, 8'h48, '0);
        issue(rv_mem_pkg::op_lw, 8'h50, '0);
        idle(1);
        wait_load();

        // sign and zero extension on every lane
        // low half has its top bit clear, high half set
        issue(rv_mem_pkg::op_sw, 8'h60, 32'h807f_01ff);
        for (int i = 0; i < 4; i++) begin
            issue(rv_mem_pkg::op_lb, 8'(8'h60 + i), '0);
            issue(rv_mem_pkg::op_lbu, 8'(8'h60 + i), '0);
        end
        issue(rv_mem_pkg::op_lh, 8'h60, '0);
        issue(rv_mem_pkg::op_lhu, 8'h60, '0);
        issue(rv_mem_pkg::op_lh, 8'h62, '0);
        issue(rv_mem_pkg::op_lhu, 8'h62, '0);
        idle(1);
        wait_load();

        // misaligned accesses, then an aligned look at the same word
        issue(rv_mem_pkg::op_lh, 8'h61, '0);
        issue(rv_mem_pkg::op_lw, 8'h62, '0);
        issue(rv_mem_pkg::op_sh, 8'h63, 32'hffff_ffff);
        issue(rv_mem_pkg::op_sw, 8'h61, 32'h0bad_f00d);
        issue(rv_mem_pkg::op_lw, 8'h60, '0);
        idle(1);
        wait_load();

        // random mix, mostly aligned, a few idle cycles
        for (int k = 0; k < n_random; k++) begin
            r_op   = rv_mem_pkg::mem_op_e'(3'(rand_bits(3)));
            r_addr = 8'(rand_bits(8));
            if (rand_bits(2) != 0) begin
                case (op_bytes(r_op))
                    2: r_addr[0] = 1'b0;
                    4: r_addr[1:0] = 2'b00;
                    default: ;
                endcase
            end
            if (rand_bits(3) == 0) begin
                idle(1);
            end else begin
                issue(r_op, r_addr, rand_bits(32));
            end
        end
        issue(rv_mem_pkg::op_lw, 8'h00, '0);
        idle(1);
        wait_load();
        idle(2);

        $display("errors: value %0d, handshake %0d, timeout %0d",
                 n_value_err, n_proto_err, n_timeout);
        if (n_value_err + n_proto_err + n_timeout == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
rv_mem_pkg.sv
store_align.sv
data_mem.sv
load_extend.sv
dmem_subsys.sv
tb_dmem_subsys.sv

//--- Makefile
# Verilator build and run for the data memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_dmem_subsys
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= >>> FAIL

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard *.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with verilator, run, search $(LOG) for the fail message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "overridable: VERILATOR TOP FLIST OBJ_DIR LOG VFLAGS"

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

test: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q -- '$(FAIL_MSG)' $(LOG); then \
	    echo "simulation reported failure, see $(LOG)"; \
	    exit 1; \
	elif ! grep -q -- '>>> PASS' $(LOG); then \
	    echo "simulation ended without a result, see $(LOG)"; \
	    exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
